/* common/play_pkg.sv */
package play_pkg;

    // Octave code in [8:7] and one-hot keys C..B in [6:0]
    typedef logic [8:0]  note_t;
    typedef logic [6:0]  idx_t;
    typedef logic [13:0] score_t;
    typedef logic [7:0]  led_t;
    typedef logic [1:0]  digit_t;
    typedef logic [7:0]  half_t;

    typedef enum logic [1:0] {
        IDLE,
        COUNTDOWN,
        PLAYING,
        DONE
    } play_state_t;

    localparam int CHART_DEPTH = 64;

    localparam logic [1:0] OCT_MID  = 2'b00;
    localparam logic [1:0] OCT_LOW  = 2'b01;
    localparam logic [1:0] OCT_HIGH = 2'b10;

    // Sized for simulation and changed only for hardware
    localparam int SCAN_DIV        = 100;
    localparam int SCANS_PER_STEP  = 2;
    localparam int STEPS_PER_DIGIT = 2;

    localparam int SCAN_W     = $clog2(SCAN_DIV);
    localparam int PHASE_W    = (SCANS_PER_STEP > 1) ? $clog2(SCANS_PER_STEP) : 1;
    localparam int STEP_CNT_W = (STEPS_PER_DIGIT > 1) ? $clog2(STEPS_PER_DIGIT) : 1;

    localparam digit_t DIGIT_FIRST = 2'd3;

    localparam score_t PTS_PERFECT = 14'd10;
    localparam score_t PTS_GREAT   = 14'd8;
    localparam score_t PTS_GOOD    = 14'd5;
    localparam score_t SCORE_MAX   = '1;

    function automatic logic note_valid(input note_t n);
        return (n[8:7] != 2'b11) && ($countones(n[6:0]) == 1);
    endfunction

    // Half-period in cycles or 0 for silence
    function automatic half_t tone_half_period(input note_t n);
        half_t base;
        case (n[6:0])
            7'b0000001: base = 8'd30;
            7'b0000010: base = 8'd27;
            7'b0000100: base = 8'd24;
            7'b0001000: base = 8'd22;
            7'b0010000: base = 8'd20;
            7'b0100000: base = 8'd18;
            7'b1000000: base = 8'd16;
            default:    base = 8'd0;
        endcase
        case (n[8:7])
            OCT_MID:  return base;
            OCT_LOW:  return base << 1;
            OCT_HIGH: return base >> 1;
            default:  return 8'd0;
        endcase
    endfunction

    function automatic led_t led_pattern(input note_t n);
        led_t l;
        l = '0;
        if (note_valid(n)) begin
            for (int k = 0; k < 7; k++) begin
                l[7-k] = n[k];
            end
            l[0] = (n[8:7] != OCT_MID);
        end
        return l;
    endfunction

endpackage

/* filelist.f */
+incdir+verification
common/play_pkg.sv
hw/play_timebase.sv
hw/sequencer/chart_store.sv
hw/sequencer/play_sequencer.sv
hw/scoring/score_keeper.sv
hw/sound/tone_gen.sv
hw/play_top.sv
verification/play_tb.sv

/* hw/play_timebase.sv */
`timescale 1ns/1ns

module play_timebase (
    input  logic prog_clk,
    input  logic rst,
    output logic scan_tick,
    output logic step_tick
);
    import play_pkg::*;

    logic [SCAN_W-1:0]  scan_cnt;
    logic [PHASE_W-1:0] phase;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            scan_cnt  <= '0;
            phase     <= '0;
            scan_tick <= 1'b0;
            step_tick <= 1'b0;
        end else begin
            scan_tick <= 1'b0;
            step_tick <= 1'b0;
            if (scan_cnt == SCAN_W'(SCAN_DIV - 1)) begin
                scan_cnt  <= '0;
                scan_tick <= 1'b1;
                // Last scan of a step doubles as the step tick
                if (phase == PHASE_W'(SCANS_PER_STEP - 1)) begin
                    phase     <= '0;
                    step_tick <= 1'b1;
                end else begin
                    phase <= phase + 1'b1;
                end
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

endmodule

/* hw/play_top.sv */
`timescale 1ns/1ns

module play_top (
    input  logic             prog_clk,
    input  logic             rst,
    input  logic             start,
    input  logic             chart_we,
    input  logic [5:0]       chart_addr,
    input  play_pkg::note_t  chart_note,
    input  play_pkg::idx_t   chart_len,
    input  play_pkg::note_t  user_keys,
    output play_pkg::digit_t count_digit,
    output logic             playing,
    output logic             done,
    output play_pkg::idx_t   note_index,
    output play_pkg::note_t  cur_note,
    output play_pkg::led_t   led,
    output play_pkg::score_t score,
    output logic             tone
);
    import play_pkg::*;

    logic       scan_tick;
    logic       step_tick;
    logic [5:0] rd_addr;
    note_t      rd_note;

    play_timebase u_timebase (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .step_tick (step_tick)
    );

    chart_store u_chart (
        .prog_clk   (prog_clk),
        .chart_we   (chart_we),
        .chart_addr (chart_addr),
        .chart_note (chart_note),
        .rd_addr    (rd_addr),
        .rd_note    (rd_note)
    );

    play_sequencer u_seq (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .start       (start),
        .step_tick   (step_tick),
        .chart_len   (chart_len),
        .rd_note     (rd_note),
        .rd_addr     (rd_addr),
        .count_digit (count_digit),
        .playing     (playing),
        .done        (done),
        .note_index  (note_index),
        .cur_note    (cur_note),
        .led         (led)
    );

    score_keeper u_score (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .start     (start),
        .scan_tick (scan_tick),
        .playing   (playing),
        .cur_note  (cur_note),
        .user_keys (user_keys),
        .score     (score)
    );

    tone_gen u_tone (
        .prog_clk (prog_clk),
        .rst      (rst),
        .cur_note (cur_note),
        .tone     (tone)
    );

endmodule

/* hw/scoring/score_keeper.sv */
`timescale 1ns/1ns

module score_keeper (
    input  logic             prog_clk,
    input  logic             rst,
    input  logic             start,
    input  logic             scan_tick,
    input  logic             playing,
    input  play_pkg::note_t  cur_note,
    input  play_pkg::note_t  user_keys,
    output play_pkg::score_t score
);
    import play_pkg::*;

    // Key samples one, two and three scans back
    note_t  hist1;
    note_t  hist2;
    note_t  hist3;
    score_t pts;
    logic [14:0] sum;

    // First matching window wins
    always_comb begin
        pts = '0;
        if (note_valid(cur_note)) begin
            if (cur_note == user_keys || cur_note == hist1) begin
                pts = PTS_PERFECT;
            end else if (cur_note == hist2) begin
                pts = PTS_GREAT;
            end else if (cur_note == hist3) begin
                pts = PTS_GOOD;
            end
        end
    end

    assign sum = {1'b0, score} + {1'b0, pts};

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
            hist1 <= '0;
            hist2 <= '0;
            hist3 <= '0;
        end else if (start && !playing) begin
            score <= '0;
            hist1 <= '0;
            hist2 <= '0;
            hist3 <= '0;
        end else if (scan_tick && playing) begin
            if (sum > {1'b0, SCORE_MAX}) begin
                score <= SCORE_MAX;
            end else begin
                score <= sum[13:0];
            end
            hist3 <= hist2;
            hist2 <= hist1;
            hist1 <= user_keys;
        end
    end

endmodule

/* hw/sequencer/chart_store.sv */
`timescale 1ns/1ns

module chart_store (
    input  logic            prog_clk,
    input  logic            chart_we,
    input  logic [5:0]      chart_addr,
    input  play_pkg::note_t chart_note,
    input  logic [5:0]      rd_addr,
    output play_pkg::note_t rd_note
);
    import play_pkg::*;

    note_t mem [CHART_DEPTH];

    always_ff @(posedge prog_clk) begin
        if (chart_we) begin
            mem[chart_addr] <= chart_note;
        end
    end

    // Asynchronous read so the sequencer loads the note on the step edge
    assign rd_note = mem[rd_addr];

endmodule

/* hw/sequencer/play_sequencer.sv */
`timescale 1ns/1ns

module play_sequencer (
    input  logic             prog_clk,
    input  logic             rst,
    input  logic             start,
    input  logic             step_tick,
    input  play_pkg::idx_t   chart_len,
    input  play_pkg::note_t  rd_note,
    output logic [5:0]       rd_addr,
    output play_pkg::digit_t count_digit,
    output logic             playing,
    output logic             done,
    output play_pkg::idx_t   note_index,
    output play_pkg::note_t  cur_note,
    output play_pkg::led_t   led
);
    import play_pkg::*;

    play_state_t           state;
    logic [STEP_CNT_W-1:0] step_cnt;
    logic                  digit_end;

    assign rd_addr   = note_index[5:0];
    assign playing   = (state == PLAYING);
    assign done      = (state == DONE);
    assign digit_end = (step_cnt == STEP_CNT_W'(STEPS_PER_DIGIT - 1));

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            step_cnt    <= '0;
            count_digit <= '0;
            note_index  <= '0;
            cur_note    <= '0;
            led         <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state       <= COUNTDOWN;
                        step_cnt    <= '0;
                        count_digit <= DIGIT_FIRST;
                        note_index  <= '0;
                        cur_note    <= '0;
                        led         <= '0;
                    end
                end

                COUNTDOWN: begin
                    if (step_tick) begin
                        if (digit_end) begin
                            step_cnt <= '0;
                            if (count_digit == 2'd1) begin
                                // Note 0 goes out on the edge that ends the last digit
                                state       <= PLAYING;
                                count_digit <= '0;
                                cur_note    <= rd_note;
                                led         <= led_pattern(rd_note);
                                note_index  <= note_index + 1'b1;
                            end else begin
                                count_digit <= count_digit - 1'b1;
                            end
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                        end
                    end
                end

                PLAYING: begin
                    if (step_tick) begin
                        if (note_index >= chart_len) begin
                            state    <= DONE;
                            cur_note <= '0;
                            led      <= '0;
                        end else begin
                            cur_note   <= rd_note;
                            led        <= led_pattern(rd_note);
                            note_index <= note_index + 1'b1;
                        end
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/sound/tone_gen.sv */
`timescale 1ns/1ns

module tone_gen (
    input  logic            prog_clk,
    input  logic            rst,
    input  play_pkg::note_t cur_note,
    output logic            tone
);
    import play_pkg::*;

    note_t prev_note;
    half_t half;
    half_t cnt;
    logic  note_change;

    assign half        = tone_half_period(cur_note);
    assign note_change = (cur_note != prev_note);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            prev_note <= '0;
            cnt       <= '0;
            tone      <= 1'b0;
        end else begin
            prev_note <= cur_note;
            if (half == '0) begin
                // Rest or invalid note stays silent
                cnt  <= '0;
                tone <= 1'b0;
            end else if (note_change) begin
                // New pitch restarts low
                cnt  <= half - 1'b1;
                tone <= 1'b0;
            end else if (cnt == '0) begin
                cnt  <= half - 1'b1;
                tone <= ~tone;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

/* verification/play_model.svh */
`ifndef PLAY_MODEL_SVH
`define PLAY_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

// Position of the set key bit with C as 0
function automatic int key_of(input logic [8:0] n);
    int k_at;
    k_at = 0;
    for (int k = 0; k < 7; k++) begin
        if (n[k]) begin
            k_at = k;
        end
    end
    return k_at;
endfunction

function automatic bit note_is_valid(input logic [8:0] n);
    int ones;
    ones = 0;
    for (int k = 0; k < 7; k++) begin
        ones = ones + n[k];
    end
    return (n[8:7] != 2'b11) && (ones == 1);
endfunction

function automatic logic [7:0] led_for_note(input logic [8:0] n);
    if (!note_is_valid(n)) begin
        return 8'h00;
    end
    return (8'h80 >> key_of(n)) | {7'd0, n[8:7] != 2'b00};
endfunction

function automatic int half_period_for_note(input logic [8:0] n);
    int h;
    if (!note_is_valid(n)) begin
        return 0;
    end
    case (key_of(n))
        0: h = 30;
        1: h = 27;
        2: h = 24;
        3: h = 22;
        4: h = 20;
        5: h = 18;
        default: h = 16;
    endcase
    if (n[8:7] == 2'b01) begin
        h = h * 2;
    end else if (n[8:7] == 2'b10) begin
        h = h / 2;
    end
    return h;
endfunction

// Key sample taken at scan t with two scans per step
function automatic logic [8:0] sample_at(input int t);
    return (t < 0) ? 9'd0 : keys_plan[t / 2];
endfunction

// Walks every scan of the play over the chart and key plan arrays
function automatic int final_score(input int len);
    logic [8:0] cur;
    int total;
    total = 0;
    for (int t = 0; t < 2 * len; t++) begin
        cur = chart[t / 2];
        if (note_is_valid(cur)) begin
            if (cur == sample_at(t) || cur == sample_at(t - 1)) begin
                total = total + 10;
            end else if (cur == sample_at(t - 2)) begin
                total = total + 8;
            end else if (cur == sample_at(t - 3)) begin
                total = total + 5;
            end
        end
        if (total > 16383) begin
            total = 16383;
        end
    end
    return total;
endfunction

`endif

/* verification/play_tb.sv */
`timescale 1ns/1ns

module play_tb;
    import play_pkg::*;

    localparam logic [31:0] SEED = 32'h51213a51;
    localparam int STEP_CYCLES  = SCAN_DIV * SCANS_PER_STEP;
    localparam int DIGIT_CYCLES = STEP_CYCLES * STEPS_PER_DIGIT;
    // Two full plays with countdowns and chart loads plus a third as margin
    localparam int RUN_CYCLES  =
        2 * ((3 * STEPS_PER_DIGIT + CHART_DEPTH + 1) * STEP_CYCLES + CHART_DEPTH);
    localparam int CYCLE_LIMIT = RUN_CYCLES + RUN_CYCLES / 3;

    logic       prog_clk;
    logic       rst;
    logic       start;
    logic       chart_we;
    logic [5:0] chart_addr;
    note_t      chart_note;
    idx_t       chart_len;
    note_t      user_keys;
    digit_t     count_digit;
    logic       playing;
    logic       done;
    idx_t       note_index;
    note_t      cur_note;
    led_t       led;
    score_t     score;
    logic       tone;

    note_t       chart [CHART_DEPTH];
    note_t       keys_plan [CHART_DEPTH];
    logic [31:0] rng;
    int          cycle;
    int          err_value;
    int          err_other;
    int          notes_seen;
    int          len2;

    idx_t  last_index;
    note_t tone_note;
    note_t prev_cur;
    note_t exp_note;
    logic  last_tone;
    int    last_edge;
    int    change_cycle;
    int    half_now;
    bit    edge_valid;

    `include "play_model.svh"

    play_top i_dut (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .start       (start),
        .chart_we    (chart_we),
        .chart_addr  (chart_addr),
        .chart_note  (chart_note),
        .chart_len   (chart_len),
        .user_keys   (user_keys),
        .count_digit (count_digit),
        .playing     (playing),
        .done        (done),
        .note_index  (note_index),
        .cur_note    (cur_note),
        .led         (led),
        .score       (score),
        .tone        (tone)
    );

    initial begin
        prog_clk = 1'b0;
        forever #4 prog_clk = ~prog_clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_value = err_value + 1;
        $display("FAIL t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic report_problem(input string msg);
        err_other = err_other + 1;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    task automatic print_error_counts;
        $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    endtask

    function automatic note_t valid_note(input logic [31:0] r);
        logic [1:0] oct;
        oct = r[17:16] % 3;
        return {oct, 7'b0000001 << (r[27:24] % 7)};
    endfunction

    // Rests, invalid notes, repeats and random valid notes
    task automatic make_chart(input int len);
        for (int i = 0; i < len; i++) begin
            rng = xorshift32(rng);
            case (rng[2:0])
                3'd0: chart[i] = '0;
                3'd1: chart[i] = rng[3] ? {2'b11, 7'b0000001 << (rng[10:8] % 7)}
                                        : {2'b00, 7'b0000011 << (rng[10:8] % 6)};
                3'd2, 3'd3: chart[i] = (i > 0) ? chart[i - 1] : 9'd0;
                default: chart[i] = valid_note(rng);
            endcase
        end
    endtask

    // Per step the player is exact, one step late or random
    task automatic make_key_plan(input int len);
        for (int j = 0; j < len; j++) begin
            rng = xorshift32(rng);
            case (rng[7:0] % 3)
                0: keys_plan[j] = chart[j];
                1: keys_plan[j] = (j > 0) ? chart[j - 1] : 9'd0;
                default: keys_plan[j] = valid_note(rng);
            endcase
        end
    endtask

    task automatic load_chart(input int len);
        for (int i = 0; i < len; i++) begin
            chart_we   = 1'b1;
            chart_addr = i;
            chart_note = chart[i];
            @(posedge prog_clk);
            #1;
        end
        chart_we = 1'b0;
    endtask

    task automatic run_play(input int len);
        digit_t last_digit;
        int     since;
        int     play_cycle;
        int     exp_score;
        chart_len  = len;
        notes_seen = 0;
        start      = 1'b1;
        @(posedge prog_clk);
        #1;
        start = 1'b0;
        if (count_digit !== 2'd3) begin
            report_mismatch("count_digit", count_digit, 3);
        end
        if (score !== '0) begin
            report_mismatch("score", score, 0);
        end
        last_digit = count_digit;
        since      = cycle;
        while (!playing) begin
            @(posedge prog_clk);
            #1;
            if (!playing && count_digit !== last_digit) begin
                if (last_digit == 2'd1) begin
                    report_problem("count_digit left 1 before playing rose");
                end else if (count_digit !== last_digit - 2'd1) begin
                    report_mismatch("count_digit", count_digit, last_digit - 2'd1);
                end else if (last_digit == 2'd2 && cycle - since != DIGIT_CYCLES) begin
                    report_problem("countdown digit 2 had the wrong length");
                end
                last_digit = count_digit;
                since      = cycle;
            end
        end
        if (last_digit != 2'd1) begin
            report_problem("playing rose before digit 1 was shown");
        end else if (cycle - since != DIGIT_CYCLES) begin
            report_problem("countdown digit 1 had the wrong length");
        end
        if (count_digit !== 2'd0) begin
            report_mismatch("count_digit", count_digit, 0);
        end
        play_cycle = cycle;
        while (!done) begin
            @(posedge prog_clk);
            #1;
        end
        if (cycle - play_cycle != len * STEP_CYCLES) begin
            report_problem($sformatf("play lasted %0d cycles for %0d notes",
                                     cycle - play_cycle, len));
        end
        if (notes_seen != len) begin
            report_problem($sformatf("%0d notes played instead of %0d", notes_seen, len));
        end
        exp_score = final_score(len);
        if (score !== exp_score) begin
            report_mismatch("score", score, exp_score);
        end
        if (note_index !== len) begin
            report_mismatch("note_index", note_index, len);
        end
        if (playing !== 1'b0 || cur_note !== '0 || led !== '0) begin
            report_problem("playing, cur_note or led still active at done");
        end
    endtask

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        chart_we     = 1'b0;
        chart_addr   = '0;
        chart_note   = '0;
        chart_len    = '0;
        user_keys    = '0;
        rng          = SEED;
        cycle        = 0;
        err_value    = 0;
        err_other    = 0;
        notes_seen   = 0;
        last_index   = '0;
        tone_note    = '0;
        prev_cur     = '0;
        last_tone    = 1'b0;
        last_edge    = 0;
        change_cycle = 0;
        edge_valid   = 1'b0;
        repeat (10) @(posedge prog_clk);
        #1;
        rst = 1'b0;
        @(posedge prog_clk);
        #1;
        if (playing !== 1'b0 || done !== 1'b0 || tone !== 1'b0) begin
            report_problem("playing, done or tone not low after reset");
        end
        if (count_digit !== 2'd0) begin
            report_mismatch("count_digit", count_digit, 0);
        end
        if (led !== '0) begin
            report_mismatch("led", led, 0);
        end
        if (score !== '0) begin
            report_mismatch("score", score, 0);
        end

        make_chart(CHART_DEPTH);
        make_key_plan(CHART_DEPTH);
        load_chart(CHART_DEPTH);
        run_play(CHART_DEPTH);

        // Second chart is shorter and loads while the first play sits in DONE
        rng  = xorshift32(rng);
        len2 = 16 + rng[15:0] % 33;
        make_chart(len2);
        make_key_plan(len2);
        load_chart(len2);
        if (note_index !== CHART_DEPTH) begin
            report_mismatch("note_index", note_index, CHART_DEPTH);
        end
        if (cur_note !== '0 || led !== '0) begin
            report_problem("cur_note or led not dark while in DONE");
        end
        run_play(len2);

        print_error_counts;
        if (err_value + err_other == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Per-cycle playback, LED and tone comparison that also drives the keys
    always @(posedge prog_clk) begin
        #1;
        if (!rst) begin
            if (note_index !== last_index) begin
                if (playing && note_index != 0) begin
                    notes_seen = notes_seen + 1;
                    exp_note   = chart[note_index - 1];
                    if (cur_note !== exp_note) begin
                        report_mismatch("cur_note", cur_note, exp_note);
                    end
                    if (led !== led_for_note(exp_note)) begin
                        report_mismatch("led", led, led_for_note(exp_note));
                    end
                    user_keys = keys_plan[note_index - 1];
                end else begin
                    user_keys = '0;
                end
                last_index = note_index;
            end
            half_now = half_period_for_note(cur_note);
            if (cur_note !== tone_note) begin
                tone_note    = cur_note;
                change_cycle = cycle;
                edge_valid   = 1'b0;
            end
            if (tone !== last_tone) begin
                if (edge_valid && half_now != 0 && cycle - last_edge != half_now) begin
                    report_mismatch("tone edge spacing", cycle - last_edge, half_now);
                end
                // Edges from the cycle after a note change onward are interior
                last_edge  = cycle;
                edge_valid = (cycle > change_cycle);
                last_tone  = tone;
            end
            if (cur_note === prev_cur && half_now == 0 && tone !== 1'b0) begin
                report_problem("tone high during a rest or invalid note");
            end
            prev_cur = cur_note;
        end
    end

    always @(posedge prog_clk) begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            err_other = err_other + 1;
            $display("ERROR t=%0t run did not finish within %0d cycles", $time, CYCLE_LIMIT);
            print_error_counts;
            $display("Simulation failed");
            $finish;
        end
    end

endmodule
